/* design/conv_accel_top.sv */
module conv_accel_top #(
    parameter int N_COLS = 4,
    parameter int FEATURE_DEPTH = 64
) (
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  dram_pkg::dram_word_u                 mem_data_i,
    input  logic                                 mem_valid_i,
    output sa_pkg::acc_t                         final_output_o,
    output logic                                 done_o,
    output logic [dram_pkg::DRAM_ADDR_WIDTH-1:0] dram_rd_address_o
);

    localparam int WAW = $clog2(N_COLS);
    localparam int FAW = $clog2(FEATURE_DEPTH);

    ////////////////////
    // load side

    logic word_valid;
    logic flush;
    logic row_valid;
    sa_pkg::row_t unpacked_row;
    logic weight_we;
    logic [WAW-1:0] weight_wr_addr;
    logic feature_we;
    logic [FAW-1:0] feature_wr_addr;
    logic start;
    logic [7:0] feature_rows;
    logic [7:0] out_col;

    ////////////////////
    // compute side

    logic weight_re;
    logic [WAW-1:0] weight_rd_addr;
    logic feature_re;
    logic [FAW-1:0] feature_rd_addr;
    sa_pkg::row_t weight_row;
    sa_pkg::row_t feature_row;
    logic weight_ld;
    logic [WAW-1:0] weight_col;
    sa_pkg::feature_slot_t slot;
    sa_pkg::acc_t [N_COLS-1:0] results;
    logic last_out;

    dram_unpacker u_unpacker (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .word_valid_i  (word_valid),
        .word_i        (mem_data_i),
        .flush_i       (flush),
        .row_valid_o   (row_valid),
        .row_o         (unpacked_row)
    );

    dram_access_ctrl #(
        .N_COLS        (N_COLS),
        .FEATURE_DEPTH (FEATURE_DEPTH)
    ) u_access_ctrl (
        .clk_i             (clk_i),
        .rd_weight_rst     (rd_weight_rst),
        .mem_valid_i       (mem_valid_i),
        .mem_data_i        (mem_data_i),
        .row_valid_i       (row_valid),
        .done_i            (done_o),
        .word_valid_o      (word_valid),
        .flush_o           (flush),
        .weight_we_o       (weight_we),
        .weight_wr_addr_o  (weight_wr_addr),
        .feature_we_o      (feature_we),
        .feature_wr_addr_o (feature_wr_addr),
        .start_o           (start),
        .feature_rows_o    (feature_rows),
        .out_col_o         (out_col),
        .dram_rd_address_o (dram_rd_address_o)
    );

    row_ram #(.DEPTH(N_COLS)) u_weight_ram (
        .clk_i     (clk_i),
        .we_i      (weight_we),
        .wr_addr_i (weight_wr_addr),
        .wr_row_i  (unpacked_row),
        .re_i      (weight_re),
        .rd_addr_i (weight_rd_addr),
        .rd_row_o  (weight_row)
    );

    row_ram #(.DEPTH(FEATURE_DEPTH)) u_feature_ram (
        .clk_i     (clk_i),
        .we_i      (feature_we),
        .wr_addr_i (feature_wr_addr),
        .wr_row_i  (unpacked_row),
        .re_i      (feature_re),
        .rd_addr_i (feature_rd_addr),
        .rd_row_o  (feature_row)
    );

    sa_controller #(
        .N_COLS        (N_COLS),
        .FEATURE_DEPTH (FEATURE_DEPTH)
    ) u_sa_ctrl (
        .clk_i             (clk_i),
        .rd_weight_rst     (rd_weight_rst),
        .start_i           (start),
        .feature_rows_i    (feature_rows),
        .out_col_i         (out_col),
        .weight_row_i      (weight_row),
        .feature_row_i     (feature_row),
        .results_i         (results),
        .last_out_i        (last_out),
        .weight_re_o       (weight_re),
        .weight_rd_addr_o  (weight_rd_addr),
        .feature_re_o      (feature_re),
        .feature_rd_addr_o (feature_rd_addr),
        .weight_ld_o       (weight_ld),
        .weight_col_o      (weight_col),
        .slot_o            (slot),
        .final_output_o    (final_output_o),
        .done_o            (done_o)
    );

    systolic_array #(.N_COLS(N_COLS)) u_array (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .weight_ld_i   (weight_ld),
        .weight_col_i  (weight_col),
        .weight_row_i  (weight_row),
        .slot_i        (slot),
        .results_o     (results),
        .last_out_o    (last_out)
    );

endmodule

/* design/dram_access_ctrl.sv */
module dram_access_ctrl #(
    parameter int N_COLS = 4,
    parameter int FEATURE_DEPTH = 64
) (
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  logic                                 mem_valid_i,
    input  dram_pkg::dram_word_u                 mem_data_i,
    input  logic                                 row_valid_i,
    input  logic                                 done_i,
    output logic                                 word_valid_o,
    output logic                                 flush_o,
    output logic                                 weight_we_o,
    output logic [$clog2(N_COLS)-1:0]            weight_wr_addr_o,
    output logic                                 feature_we_o,
    output logic [$clog2(FEATURE_DEPTH)-1:0]     feature_wr_addr_o,
    output logic                                 start_o,
    output logic [7:0]                           feature_rows_o,
    output logic [7:0]                           out_col_o,
    output logic [dram_pkg::DRAM_ADDR_WIDTH-1:0] dram_rd_address_o
);

    localparam int WAW = $clog2(N_COLS);
    localparam int FAW = $clog2(FEATURE_DEPTH);

    dram_pkg::load_phase_e phase_q;
    dram_pkg::dram_param_t param_q;
    logic [FAW-1:0] row_cnt_q;
    logic last_weight;
    logic last_feature;

    ////////////////////
    // row steering

    // parameter word is kept here, everything else goes to the unpacker
    assign word_valid_o = mem_valid_i && (phase_q == dram_pkg::PHASE_WEIGHT ||
                                          phase_q == dram_pkg::PHASE_FEATURE);
    assign weight_we_o = row_valid_i && phase_q == dram_pkg::PHASE_WEIGHT;
    assign feature_we_o = row_valid_i && phase_q == dram_pkg::PHASE_FEATURE;
    assign weight_wr_addr_o = row_cnt_q[WAW-1:0];
    assign feature_wr_addr_o = row_cnt_q;

    assign last_weight = weight_we_o && row_cnt_q == FAW'(N_COLS - 1);
    assign last_feature = feature_we_o && row_cnt_q == FAW'(param_q.feature_rows - 8'd1);
    // region end, leftover bytes are padding
    assign flush_o = last_weight || last_feature;

    assign feature_rows_o = param_q.feature_rows;
    assign out_col_o = param_q.out_col;

    ////////////////////
    // phase sequencing

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            phase_q <= dram_pkg::PHASE_PARAM;
            row_cnt_q <= '0;
            start_o <= 1'b0;
            dram_rd_address_o <= '0;
        end else begin
            start_o <= last_feature;
            if (mem_valid_i) begin
                dram_rd_address_o <= (phase_q == dram_pkg::PHASE_PARAM) ?
                                     dram_pkg::DRAM_ADDR_WIDTH'(1) : dram_rd_address_o + 1'b1;
            end
            if (weight_we_o || feature_we_o) begin
                row_cnt_q <= flush_o ? '0 : row_cnt_q + 1'b1;
            end
            case (phase_q)
                dram_pkg::PHASE_PARAM: if (mem_valid_i) phase_q <= dram_pkg::PHASE_WEIGHT;
                dram_pkg::PHASE_WEIGHT: if (last_weight) phase_q <= dram_pkg::PHASE_FEATURE;
                dram_pkg::PHASE_FEATURE: if (last_feature) phase_q <= dram_pkg::PHASE_COMPUTE;
                default: if (done_i) phase_q <= dram_pkg::PHASE_PARAM;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_valid_i && phase_q == dram_pkg::PHASE_PARAM) begin
            param_q <= mem_data_i.param;
        end
    end

    // the array and the result mux are sized from these parameters
    a_param_range: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        (mem_valid_i && phase_q == dram_pkg::PHASE_PARAM) |->
        (mem_data_i.param.out_col < N_COLS && mem_data_i.param.feature_rows >= 1 &&
         mem_data_i.param.feature_rows <= FEATURE_DEPTH));

    // no back-pressure, so a word during compute would be lost
    a_no_word_in_compute: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        phase_q == dram_pkg::PHASE_COMPUTE |-> !mem_valid_i);

endmodule

/* design/dram_pkg.sv */
package dram_pkg;

    localparam int DRAM_WORD_WIDTH = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int DRAM_ADDR_WIDTH = 18;

    // first word of every job
    typedef struct packed {
        logic [7:0]  feature_rows;
        logic [7:0]  out_col;
        logic [15:0] reserved;
    } dram_param_t;

    // one bus word, seen either as bytes or as the job parameters
    // byte 0 sits in the low bits
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][DRAM_WORD_WIDTH/BYTES_PER_WORD-1:0] raw;
        dram_param_t param;
    } dram_word_u;

    // order in which a job is loaded
    typedef enum logic [1:0] {
        PHASE_PARAM,
        PHASE_WEIGHT,
        PHASE_FEATURE,
        PHASE_COMPUTE
    } load_phase_e;

endpackage

/* design/dram_unpacker.sv */
module dram_unpacker (
    input  logic               clk_i,
    input  logic               rd_weight_rst,
    input  logic               word_valid_i,
    input  dram_pkg::dram_word_u word_i,
    input  logic               flush_i,
    output logic               row_valid_o,
    output sa_pkg::row_t       row_o
);

    localparam int BUF_BYTES = 2 * sa_pkg::N_ROWS;
    localparam int ROW_BITS = sa_pkg::N_ROWS * sa_pkg::DATA_WIDTH;

    sa_pkg::data_t [BUF_BYTES-1:0] buf_q;
    sa_pkg::data_t [BUF_BYTES-1:0] buf_d;
    logic [2:0] cnt_q;
    logic [2:0] cnt_d;

    // oldest bytes sit at the bottom of the buffer
    assign row_valid_o = cnt_q >= 3'(sa_pkg::N_ROWS);
    assign row_o = buf_q[sa_pkg::N_ROWS-1:0];

    always_comb begin
        buf_d = buf_q;
        cnt_d = cnt_q;
        // flush drops padding, a word arriving now still lands
        if (flush_i) begin
            cnt_d = '0;
        end else if (row_valid_o) begin
            buf_d = buf_q >> ROW_BITS;
            cnt_d = cnt_q - 3'(sa_pkg::N_ROWS);
        end
        if (word_valid_i) begin
            for (int k = 0; k < dram_pkg::BYTES_PER_WORD; k++) begin
                buf_d[cnt_d + 3'(k)] = word_i.raw[k];
            end
            cnt_d = cnt_d + 3'(dram_pkg::BYTES_PER_WORD);
        end
    end

    always_ff @(posedge clk_i) begin
        buf_q <= buf_d;
        if (rd_weight_rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // with one idle cycle between words the buffer never holds more than six bytes
    a_word_spacing: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        word_valid_i |=> !word_valid_i);

endmodule

/* design/row_ram.sv */
module row_ram #(
    parameter int DEPTH = 64
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  sa_pkg::row_t             wr_row_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output sa_pkg::row_t             rd_row_o
);

    sa_pkg::row_t mem [DEPTH];

    // one cycle read latency, output holds while re_i is low
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_row_i;
        end
        if (re_i) begin
            rd_row_o <= mem[rd_addr_i];
        end
    end

endmodule

/* design/sa_controller.sv */
module sa_controller #(
    parameter int N_COLS = 4,
    parameter int FEATURE_DEPTH = 64
) (
    input  logic                             clk_i,
    input  logic                             rd_weight_rst,
    input  logic                             start_i,
    input  logic [7:0]                       feature_rows_i,
    input  logic [7:0]                       out_col_i,
    input  sa_pkg::row_t                     weight_row_i,
    input  sa_pkg::row_t                     feature_row_i,
    input  sa_pkg::acc_t [N_COLS-1:0]        results_i,
    input  logic                             last_out_i,
    output logic                             weight_re_o,
    output logic [$clog2(N_COLS)-1:0]        weight_rd_addr_o,
    output logic                             feature_re_o,
    output logic [$clog2(FEATURE_DEPTH)-1:0] feature_rd_addr_o,
    output logic                             weight_ld_o,
    output logic [$clog2(N_COLS)-1:0]        weight_col_o,
    output sa_pkg::feature_slot_t            slot_o,
    output sa_pkg::acc_t                     final_output_o,
    output logic                             done_o
);

    localparam int WAW = $clog2(N_COLS);
    localparam int FAW = $clog2(FEATURE_DEPTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_STREAM
    } state_e;

    state_e state_q;
    logic [FAW-1:0] cnt_q;
    logic last_row;
    logic fvalid_q;
    logic ffirst_q;
    logic flast_q;

    assign last_row = cnt_q == FAW'(feature_rows_i - 8'd1);

    assign weight_re_o = state_q == S_LOAD;
    assign weight_rd_addr_o = cnt_q[WAW-1:0];
    assign feature_re_o = state_q == S_STREAM;
    assign feature_rd_addr_o = cnt_q;

    // flags and the RAM output both lag the read by one cycle
    assign slot_o = '{valid: fvalid_q, first: ffirst_q, last: flast_q, row: feature_row_i};

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            state_q <= S_IDLE;
            cnt_q <= '0;
            weight_ld_o <= 1'b0;
            weight_col_o <= '0;
            fvalid_q <= 1'b0;
            ffirst_q <= 1'b0;
            flast_q <= 1'b0;
            done_o <= 1'b0;
            final_output_o <= '0;
        end else begin
            // load follows the weight read by one cycle
            weight_ld_o <= state_q == S_LOAD;
            weight_col_o <= cnt_q[WAW-1:0];
            fvalid_q <= state_q == S_STREAM;
            ffirst_q <= state_q == S_STREAM && cnt_q == '0;
            flast_q <= state_q == S_STREAM && last_row;
            done_o <= last_out_i;
            if (last_out_i) begin
                final_output_o <= results_i[out_col_i];
            end
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_LOAD;
                        cnt_q <= '0;
                    end
                end
                S_LOAD: begin
                    if (cnt_q == FAW'(N_COLS - 1)) begin
                        state_q <= S_STREAM;
                        cnt_q <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (last_row) begin
                        state_q <= S_IDLE;
                        cnt_q <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* design/sa_pkg.sv */
package sa_pkg;

    // taps per row
    localparam int N_ROWS = 3;
    localparam int DATA_WIDTH = 8;
    localparam int ACC_WIDTH = 16;

    typedef logic signed [DATA_WIDTH-1:0] data_t;

    // wraps modulo 2^16
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // element 0 is the earliest byte of the stream
    typedef data_t [N_ROWS-1:0] row_t;

    // one feature row travelling down the array
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
        row_t row;
    } feature_slot_t;

endpackage

/* design/systolic_array.sv */
module systolic_array #(
    parameter int N_COLS = 4
) (
    input  logic                      clk_i,
    input  logic                      rd_weight_rst,
    input  logic                      weight_ld_i,
    input  logic [$clog2(N_COLS)-1:0] weight_col_i,
    input  sa_pkg::row_t              weight_row_i,
    input  sa_pkg::feature_slot_t     slot_i,
    output sa_pkg::acc_t [N_COLS-1:0] results_o,
    output logic                      last_out_o
);

    localparam int CW = $clog2(N_COLS);

    // entry c is the slot seen by column c, entry N_COLS has left the array
    sa_pkg::feature_slot_t [N_COLS:0] slot_chain;

    function automatic sa_pkg::acc_t dot(sa_pkg::row_t a, sa_pkg::row_t b);
        sa_pkg::acc_t sum;
        sa_pkg::acc_t prod;
        sum = '0;
        for (int k = 0; k < sa_pkg::N_ROWS; k++) begin
            prod = a[k] * b[k];
            sum = sum + prod;
        end
        return sum;
    endfunction

    assign slot_chain[0] = slot_i;
    assign last_out_o = slot_chain[N_COLS].valid && slot_chain[N_COLS].last;

    for (genvar c = 0; c < N_COLS; c++) begin : g_col
        sa_pkg::row_t weight_q;

        always_ff @(posedge clk_i) begin
            if (rd_weight_rst) begin
                weight_q <= '0;
                slot_chain[c+1] <= '0;
                results_o[c] <= '0;
            end else begin
                if (weight_ld_i && weight_col_i == CW'(c)) begin
                    weight_q <= weight_row_i;
                end
                slot_chain[c+1] <= slot_chain[c];
                // first row of a job restarts the sum
                if (slot_chain[c].valid) begin
                    results_o[c] <= (slot_chain[c].first ? '0 : results_o[c]) +
                                    dot(slot_chain[c].row, weight_q);
                end
            end
        end
    end

    a_weight_col: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        weight_ld_i |-> weight_col_i < N_COLS);

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_accel -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null \
    && echo PASS \
    || { echo FAIL; exit 1; }

/* tests/tb_conv_accel.sv */
module tb_conv_accel;

    localparam int N_COLS = 4;
    localparam int FEATURE_DEPTH = 64;
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;
    localparam int N_RANDOM_JOBS = 8;
    localparam int N_JOBS = N_RANDOM_JOBS + 2;
    localparam int MAX_WORDS = 1 + (3 * N_COLS + 3) / 4 + (3 * FEATURE_DEPTH + 3) / 4;
    localparam int JOB_CYCLES = 2 * MAX_WORDS + FEATURE_DEPTH + 4 * N_COLS + 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_JOBS * JOB_CYCLES;

    logic clk_i;
    logic rd_weight_rst;
    dram_pkg::dram_word_u mem_data_i;
    logic mem_valid_i;
    sa_pkg::acc_t final_output_o;
    logic done_o;
    logic [dram_pkg::DRAM_ADDR_WIDTH-1:0] dram_rd_address_o;

    // bytes of the current job in stream order
    sa_pkg::data_t w_bytes [N_COLS*sa_pkg::N_ROWS];
    sa_pkg::data_t f_bytes [FEATURE_DEPTH*sa_pkg::N_ROWS];

    sa_pkg::acc_t exp_result [$];
    int exp_count [$];
    int jobs_checked;
    logic [31:0] rand_state;

    conv_accel_top #(
        .N_COLS        (N_COLS),
        .FEATURE_DEPTH (FEATURE_DEPTH)
    ) i_conv_accel_top (
        .clk_i             (clk_i),
        .rd_weight_rst     (rd_weight_rst),
        .mem_data_i        (mem_data_i),
        .mem_valid_i       (mem_valid_i),
        .final_output_o    (final_output_o),
        .done_o            (done_o),
        .dram_rd_address_o (dram_rd_address_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////
    // helpers

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = next_random();
        return r[23:16];
    endfunction

    // dot products of every feature row with the weight row of col summed modulo 2^16
    function automatic sa_pkg::acc_t reference_sum(input int rows, input int col);
        int acc;
        acc = 0;
        for (int r = 0; r < rows; r++) begin
            for (int k = 0; k < sa_pkg::N_ROWS; k++) begin
                acc += int'(f_bytes[r*3+k]) * int'(w_bytes[col*3+k]);
            end
        end
        return acc[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "value check failed");
        end
    endtask

    // one word per strobe followed by one idle cycle
    task automatic send_word(input dram_pkg::dram_word_u word);
        @(posedge clk_i);
        #DRIVE_DELAY;
        mem_data_i = word;
        mem_valid_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        mem_valid_i = 1'b0;
    endtask

    // padding bytes are random junk
    task automatic send_region(input bit is_weight, input int n_bytes);
        dram_pkg::dram_word_u word;
        int idx;
        for (int w = 0; w < (n_bytes + 3) / 4; w++) begin
            for (int b = 0; b < dram_pkg::BYTES_PER_WORD; b++) begin
                idx = w * dram_pkg::BYTES_PER_WORD + b;
                if (idx >= n_bytes) begin
                    word.raw[b] = random_byte();
                end else if (is_weight) begin
                    word.raw[b] = w_bytes[idx];
                end else begin
                    word.raw[b] = f_bytes[idx];
                end
            end
            send_word(word);
        end
    endtask

    task automatic run_job(input int rows, input int col);
        dram_pkg::dram_word_u word;
        word.param.feature_rows = 8'(rows);
        word.param.out_col = 8'(col);
        word.param.reserved = 16'(next_random());
        exp_result.push_back(reference_sum(rows, col));
        exp_count.push_back(1 + (3 * N_COLS + 3) / 4 + (3 * rows + 3) / 4);
        send_word(word);
        send_region(1'b1, 3 * N_COLS);
        send_region(1'b0, 3 * rows);
        do @(negedge clk_i); while (!done_o);
    endtask

    ////////////////////
    // result checking

    initial begin
        jobs_checked = 0;
        forever begin
            @(negedge clk_i);
            if (done_o) begin
                if (exp_result.size() == 0) begin
                    $display("done_o pulsed at %0t with no job outstanding", $time);
                    $display("Test failures found");
                    $fatal(1, "unexpected done_o");
                end else begin
                    check_value("final_output_o", final_output_o, exp_result.pop_front());
                    check_value("dram_rd_address_o", dram_rd_address_o, exp_count.pop_front());
                    jobs_checked++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: done_o never arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // stimulus

    initial begin
        int rows;
        rd_weight_rst = 1'b1;
        mem_valid_i = 1'b0;
        mem_data_i = '0;
        rand_state = 32'h3cbf;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rd_weight_rst = 1'b0;

        // idle after reset
        @(negedge clk_i);
        check_value("final_output_o", final_output_o, 32'h0);
        check_value("dram_rd_address_o", dram_rd_address_o, 32'h0);
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            check_value("done_o", done_o, 32'h0);
        end

        // small hand-made job
        for (int i = 0; i < N_COLS * 3; i++) begin
            w_bytes[i] = 8'(i + 1);
        end
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 3; k++) begin
                f_bytes[r*3+k] = 8'(r + k + 1);
            end
        end
        run_job(4, 2);

        // back to back random jobs with new weights each time
        for (int j = 0; j < N_RANDOM_JOBS; j++) begin
            rows = int'(next_random() % FEATURE_DEPTH) + 1;
            if (rows % 4 == 0) begin
                rows = rows - 1;
            end
            foreach (w_bytes[i]) begin
                w_bytes[i] = random_byte();
            end
            foreach (f_bytes[i]) begin
                f_bytes[i] = random_byte();
            end
            run_job(rows, j % N_COLS);
        end

        // extreme bytes over the full depth make the sum wrap
        for (int i = 0; i < FEATURE_DEPTH * 3; i++) begin
            f_bytes[i] = (i % 3 == 1) ? 8'sh80 : 8'sh7f;
        end
        for (int i = 0; i < N_COLS * 3; i++) begin
            w_bytes[i] = (i % 3 == 1) ? 8'sh80 : 8'sh7f;
        end
        run_job(FEATURE_DEPTH, 1);

        repeat (2) @(posedge clk_i);
        if (jobs_checked == N_JOBS) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Only %0d of %0d jobs were checked", jobs_checked, N_JOBS);
            $display("Test failures found");
            $fatal(1, "missing results");
        end
    end

endmodule

/* verilog.f */
design/dram_pkg.sv
design/sa_pkg.sv
design/dram_unpacker.sv
design/dram_access_ctrl.sv
design/row_ram.sv
design/sa_controller.sv
design/systolic_array.sv
design/conv_accel_top.sv
tests/tb_conv_accel.sv
